/* filelist.f */
+incdir+tests
hdl/exu_pkg.sv
hdl/muldiv_if.sv
hdl/int_alu.sv
hdl/iter_mul.sv
hdl/iter_div.sv
hdl/exu_top.sv
tests/exu_tb.sv

/* Makefile */
# Verilator build and run of the execute unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module exu_tb -f filelist.f -o Vexu_tb
	./obj_dir/Vexu_tb | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "no pass line in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tests/exu_model.svh */
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// sign extend the low word
function automatic logic [63:0] sext_word(logic [63:0] v);
  return {{32{v[31]}}, v[31:0]};
endfunction

// expected result of one operation, from the rv64im rules
function automatic logic [63:0] model_result(exu_op_e op, logic word,
                                             logic [63:0] a, logic [63:0] b);
  logic [127:0] wa;
  logic [127:0] wb;
  logic [127:0] prod;
  logic [63:0]  x;
  logic [63:0]  y;
  logic [63:0]  q;
  logic [63:0]  r;
  logic [63:0]  res;
  logic [5:0]   sh;
  logic         sgn;

  // word shifts only see 5 bits of the amount
  sh  = word ? {1'b0, b[4:0]} : b[5:0];
  res = '0;
  case (op)
    OP_ADD:  res = a + b;
    OP_SUB:  res = a - b;
    OP_SLL:  res = a << sh;
    OP_SRL:  res = word ? ({32'b0, a[31:0]} >> sh) : (a >> sh);
    OP_SRA: begin
      x   = word ? sext_word(a) : a;
      res = $signed(x) >>> sh;
    end
    OP_AND:  res = a & b;
    OP_OR:   res = a | b;
    OP_XOR:  res = a ^ b;
    OP_SLT:  res = {63'b0, $signed(a) < $signed(b)};
    OP_SLTU: res = {63'b0, a < b};
    OP_BEQ:  res = {63'b0, a == b};
    OP_BNE:  res = {63'b0, a != b};
    OP_BLT:  res = {63'b0, $signed(a) < $signed(b)};
    OP_BGE:  res = {63'b0, $signed(a) >= $signed(b)};
    OP_BLTU: res = {63'b0, a < b};
    OP_BGEU: res = {63'b0, a >= b};
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: begin
      // full 128 bit product of the extended operands
      wa   = (op == OP_MULHU) ? {64'b0, a} : {{64{a[63]}}, a};
      wb   = (op == OP_MUL || op == OP_MULH) ? {{64{b[63]}}, b} : {64'b0, b};
      prod = wa * wb;
      res  = (op == OP_MUL) ? prod[63:0] : prod[127:64];
    end
    OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
      sgn = (op == OP_DIV) || (op == OP_REM);
      x   = a;
      y   = b;
      if (word) begin
        x = sgn ? sext_word(a) : {32'b0, a[31:0]};
        y = sgn ? sext_word(b) : {32'b0, b[31:0]};
      end
      if (y == 64'd0) begin
        q = '1;
        r = x;
      end else if (sgn && x == {1'b1, 63'b0} && y == '1) begin
        // signed overflow
        q = x;
        r = 64'd0;
      end else if (sgn) begin
        q = $signed(x) / $signed(y);
        r = $signed(x) % $signed(y);
      end else begin
        q = x / y;
        r = x % y;
      end
      res = (op == OP_DIV || op == OP_DIVU) ? q : r;
    end
    default: res = '0;
  endcase
  if (word) begin
    res = sext_word(res);
  end
  return res;
endfunction

`endif

/* tests/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;

  import exu_pkg::*;

  `include "exu_model.svh"

  localparam int N_ALU = 300;
  localparam int N_MUL = 100;
  localparam int N_DIV = 100;
  localparam int N_BP  = 100;
  // longest op is well under 80 cycles even with a stalled consumer
  localparam int LIMIT_CYCLES = (N_ALU + N_MUL + N_DIV + N_BP) * 80 + 200;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  exu_op_e     op;
  logic        word;
  logic [63:0] src1;
  logic [63:0] src2;
  logic        out_valid;
  logic        out_ready;
  logic [63:0] result;

  integer      seed = 27;
  int          errors = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  int          sent;
  int          accepted;
  int          received;
  logic [63:0] expect_q[$];
  string       desc_q[$];

  exu_top #(.XLEN(64)) UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .op_i        (op),
    .word_i      (word),
    .src1_i      (src1),
    .src2_i      (src2),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result)
  );

  always #5 clk = ~clk;

  task automatic check_value(string msg, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // corner values show up often
  function automatic logic [63:0] pick_operand();
    case ({$random(seed)} % 8)
      0: return 64'd0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7fff_ffff_ffff_ffff;
      4: return 64'h0000_0000_8000_0000;
      5: return {32'd0, $random(seed)};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic logic word_allowed(exu_op_e o);
    return o inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
                     OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  // kind 0 alu and branch, 1 multiply, 2 divide, 3 anything
  task automatic gen_op(int kind);
    int code;
    case (kind)
      0: code = {$random(seed)} % 16;
      1: code = 16 + {$random(seed)} % 4;
      2: code = 20 + {$random(seed)} % 4;
      default: code = {$random(seed)} % 24;
    endcase
    op   = exu_op_e'(code);
    word = word_allowed(op) && rand_bit();
    if (kind == 0) begin
      src1 = {$random(seed), $random(seed)};
      // equal operands now and then for the compares
      src2 = rand_bit() ? src1 : {$random(seed), $random(seed)};
    end else begin
      src1 = pick_operand();
      src2 = pick_operand();
    end
    // divide test opens with overflow and zero divisor cases
    if (kind == 2 && sent < 8) begin
      op   = (sent % 2 == 0) ? OP_DIV : OP_REM;
      word = (sent >= 2 && sent < 4) || (sent >= 6);
      src1 = word ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
      src2 = (sent < 4) ? '1 : 64'd0;
    end
  endtask

  task automatic finish_test(string name, int err0);
    if (errors == err0) begin
      tests_pass++;
      $display("test %-10s pass", name);
    end else begin
      tests_fail++;
      $display("test %-10s fail, %0d errors", name, errors - err0);
    end
  endtask

  task automatic run_test(string name, int kind, int count, logic bp);
    int          err0;
    logic        taken;
    logic        hold_chk;
    logic        alu_pending;
    logic [63:0] held;
    err0        = errors;
    sent        = 0;
    accepted    = 0;
    received    = 0;
    taken       = 1'b0;
    hold_chk    = 1'b0;
    alu_pending = 1'b0;
    held        = '0;
    while (received < count) begin
      @(posedge clk);
      #1;
      if (taken) begin
        in_valid = 1'b0;
      end
      taken = 1'b0;
      if (!in_valid && sent < count) begin
        gen_op(kind);
        in_valid = 1'b1;
        sent++;
      end
      out_ready = bp ? rand_bit() : 1'b1;
      // everything is stable until the next edge
      @(negedge clk);
      if (hold_chk) begin
        check_value("out_valid dropped under back-pressure", 64'(out_valid), 64'd1);
        check_value("result changed under back-pressure", result, held);
      end
      if (alu_pending) begin
        check_value("alu result not valid one cycle after accept", 64'(out_valid), 64'd1);
      end
      if (accepted > received) begin
        check_value("in_ready high with an op in flight", 64'(in_ready), 64'd0);
      end
      hold_chk    = out_valid && !out_ready;
      held        = result;
      alu_pending = 1'b0;
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          errors++;
          $display("result transferred at %0d ns with no operation outstanding", $time);
        end else begin
          check_value(desc_q.pop_front(), result, expect_q.pop_front());
        end
        received++;
      end
      if (in_valid && in_ready) begin
        expect_q.push_back(model_result(op, word, src1, src2));
        desc_q.push_back($sformatf("%s w=%0b a=%h b=%h", op.name(), word, src1, src2));
        accepted++;
        alu_pending = op < OP_MUL;
        taken       = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    // nothing lost or repeated
    check_value("accepted vs returned count", 64'(accepted), 64'(received));
    check_value("scoreboard left over", 64'(expect_q.size()), 64'd0);
    finish_test(name, err0);
  endtask

  // ends a hung run
  initial begin
    #(LIMIT_CYCLES * 10);
    $display("timeout: the DUT stopped returning results before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int err0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op        = OP_ADD;
    word      = 1'b0;
    src1      = '0;
    src2      = '0;
    out_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    err0 = errors;
    check_value("out_valid after reset", 64'(out_valid), 64'd0);
    check_value("in_ready after reset", 64'(in_ready), 64'd1);
    finish_test("reset", err0);

    run_test("alu", 0, N_ALU, 1'b0);
    run_test("multiply", 1, N_MUL, 1'b0);
    run_test("divide", 2, N_DIV, 1'b0);
    run_test("backpress", 3, N_BP, 1'b1);

    $display("tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps

module exu_top #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  exu_pkg::exu_op_e op_i,
  input  logic             word_i,
  input  logic [XLEN-1:0]  src1_i,
  input  logic [XLEN-1:0]  src2_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [XLEN-1:0]  result_o
);

  import exu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_HOLD
  } state_e;

  state_e          state_q;
  logic            accept;
  logic            sign_a;
  logic            sign_b;
  logic            alt;
  logic            mul_start_q;
  logic            div_start_q;
  logic            use_mul_q;
  logic            unit_done;
  logic [XLEN-1:0] unit_result;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] result_q;
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  logic            word_q;
  logic            sign_a_q;
  logic            sign_b_q;
  logic            alt_q;

  muldiv_if #(.XLEN(XLEN)) mul_bus ();
  muldiv_if #(.XLEN(XLEN)) div_bus ();

  int_alu #(.XLEN(XLEN)) u_alu (
    .op_i     (op_i),
    .word_i   (word_i),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .result_o (alu_result)
  );

  iter_mul #(.XLEN(XLEN)) u_mul (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mif     (mul_bus)
  );

  iter_div #(.XLEN(XLEN)) u_div (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mif     (div_bus)
  );

  // one op in flight, units must be idle too
  assign in_ready_o  = (state_q == ST_IDLE) && !mul_bus.busy && !div_bus.busy;
  assign accept      = in_valid_i && in_ready_o;
  assign out_valid_o = state_q == ST_HOLD;
  assign result_o    = result_q;

  // operand signedness and high/remainder select per op
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    alt    = 1'b0;
    case (op_i)
      OP_MUL, OP_DIV: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      OP_MULH, OP_REM: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
        alt    = 1'b1;
      end
      OP_MULHSU: begin
        sign_a = 1'b1;
        alt    = 1'b1;
      end
      OP_MULHU, OP_REMU: alt = 1'b1;
      default: ;
    endcase
  end

  // both buses share the captured request, only start differs
  assign mul_bus.start  = mul_start_q;
  assign mul_bus.src_a  = a_q;
  assign mul_bus.src_b  = b_q;
  assign mul_bus.word   = word_q;
  assign mul_bus.sign_a = sign_a_q;
  assign mul_bus.sign_b = sign_b_q;
  assign mul_bus.alt    = alt_q;

  assign div_bus.start  = div_start_q;
  assign div_bus.src_a  = a_q;
  assign div_bus.src_b  = b_q;
  assign div_bus.word   = word_q;
  assign div_bus.sign_a = sign_a_q;
  assign div_bus.sign_b = sign_b_q;
  assign div_bus.alt    = alt_q;

  assign unit_done   = use_mul_q ? mul_bus.done : div_bus.done;
  assign unit_result = use_mul_q ? mul_bus.result : div_bus.result;

  // dispatch fsm
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
      use_mul_q   <= 1'b0;
    end else begin
      // start is a single cycle pulse
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            if (is_mul_op(op_i)) begin
              mul_start_q <= 1'b1;
              use_mul_q   <= 1'b1;
              state_q     <= ST_WAIT;
            end else if (is_div_op(op_i)) begin
              div_start_q <= 1'b1;
              use_mul_q   <= 1'b0;
              state_q     <= ST_WAIT;
            end else begin
              state_q <= ST_HOLD;
            end
          end
        end
        ST_WAIT: begin
          if (unit_done) begin
            state_q <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          // result leaves, ready again next cycle
          if (out_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request capture and result register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q      <= src1_i;
      b_q      <= src2_i;
      word_q   <= word_i;
      sign_a_q <= sign_a;
      sign_b_q <= sign_b;
      alt_q    <= alt;
      // alu ops complete right away
      if (!is_mul_op(op_i) && !is_div_op(op_i)) begin
        result_q <= alu_result;
      end
    end else if ((state_q == ST_WAIT) && unit_done) begin
      result_q <= unit_result;
    end
  end

endmodule

/* hdl/iter_div.sv */
`timescale 1ns/1ps

module iter_div #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input logic    clk_i,
  input logic    rst_n_i,
  muldiv_if.unit mif
);

  localparam int CW = $clog2(XLEN);

  logic            run_q;
  logic            fin_q;
  logic [CW-1:0]   cnt_q;
  logic [XLEN-1:0] dvsr_q;
  // dividend bits shift out of quo_q while quotient bits shift in
  logic [XLEN-1:0] quo_q;
  logic [XLEN-1:0] rem_q;
  logic            neg_q_q;
  logic            neg_r_q;
  logic            zero_q;
  logic            alt_q;
  logic            word_q;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic            neg_a;
  logic            neg_b;
  logic            idle;
  logic [XLEN:0]   partial;
  logic [XLEN:0]   trial;
  logic [XLEN-1:0] q_fix;
  logic [XLEN-1:0] r_fix;
  logic [XLEN-1:0] sel;

  assign idle = !run_q && !fin_q;

  // word ops extend the low halves by signedness first
  always_comb begin
    if (!mif.word) begin
      a_ext = mif.src_a;
      b_ext = mif.src_b;
    end else begin
      a_ext = {{(XLEN-32){mif.sign_a && mif.src_a[31]}}, mif.src_a[31:0]};
      b_ext = {{(XLEN-32){mif.sign_b && mif.src_b[31]}}, mif.src_b[31:0]};
    end
  end

  assign neg_a = mif.sign_a && a_ext[XLEN-1];
  assign neg_b = mif.sign_b && b_ext[XLEN-1];

  // one restoring step
  assign partial = {rem_q, quo_q[XLEN-1]};
  assign trial   = partial - {1'b0, dvsr_q};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      fin_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      fin_q <= 1'b0;
      if (mif.start && idle) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CW'(XLEN-1)) begin
          run_q <= 1'b0;
          fin_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mif.start && idle) begin
      dvsr_q  <= neg_b ? -b_ext : b_ext;
      quo_q   <= neg_a ? -a_ext : a_ext;
      rem_q   <= '0;
      neg_q_q <= neg_a ^ neg_b;
      // remainder takes the dividend sign
      neg_r_q <= neg_a;
      zero_q  <= b_ext == '0;
      alt_q   <= mif.alt;
      word_q  <= mif.word;
    end else if (run_q) begin
      // no borrow means the divisor fits
      if (!trial[XLEN]) begin
        rem_q <= trial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= partial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // divide by zero forces all ones
  // the remainder already equals the dividend in that case
  // min / -1 falls out of the magnitude path as the dividend with remainder 0
  assign q_fix = zero_q ? '1 : (neg_q_q ? -quo_q : quo_q);
  assign r_fix = neg_r_q ? -rem_q : rem_q;
  assign sel   = alt_q ? r_fix : q_fix;

  assign mif.result = word_q ? {{(XLEN-32){sel[31]}}, sel[31:0]} : sel;
  assign mif.busy   = !idle;
  assign mif.done   = fin_q;

endmodule

/* hdl/iter_mul.sv */
`timescale 1ns/1ps

module iter_mul #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input logic    clk_i,
  input logic    rst_n_i,
  muldiv_if.unit mif
);

  localparam int CW = $clog2(XLEN);

  logic              run_q;
  logic              fin_q;
  logic [CW-1:0]     cnt_q;
  logic [XLEN-1:0]   mcand_q;
  // upper half accumulates, lower half holds the remaining multiplier bits
  logic [2*XLEN-1:0] prod_q;
  logic [2*XLEN-1:0] prod_fix;
  logic              neg_q;
  logic              alt_q;
  logic              word_q;
  logic              neg_a;
  logic              neg_b;
  logic              idle;
  logic [XLEN:0]     step_sum;

  assign idle  = !run_q && !fin_q;
  assign neg_a = mif.sign_a && mif.src_a[XLEN-1];
  assign neg_b = mif.sign_b && mif.src_b[XLEN-1];

  // add multiplicand when the current multiplier bit is set, keep the carry
  assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} +
                    (prod_q[0] ? {1'b0, mcand_q} : {(XLEN+1){1'b0}});

  // start, XLEN steps, one finish cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      fin_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      fin_q <= 1'b0;
      if (mif.start && idle) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CW'(XLEN-1)) begin
          run_q <= 1'b0;
          fin_q <= 1'b1;
        end
      end
    end
  end

  // operands as magnitudes, product sign kept aside
  always_ff @(posedge clk_i) begin
    if (mif.start && idle) begin
      mcand_q <= neg_a ? -mif.src_a : mif.src_a;
      prod_q  <= {{XLEN{1'b0}}, (neg_b ? -mif.src_b : mif.src_b)};
      neg_q   <= neg_a ^ neg_b;
      alt_q   <= mif.alt;
      word_q  <= mif.word;
    end else if (run_q) begin
      prod_q <= {step_sum, prod_q[XLEN-1:1]};
    end
  end

  assign prod_fix = neg_q ? -prod_q : prod_q;

  // mulw takes the low word, mulh* the upper half
  always_comb begin
    if (word_q) begin
      mif.result = {{(XLEN-32){prod_fix[31]}}, prod_fix[31:0]};
    end else if (alt_q) begin
      mif.result = prod_fix[2*XLEN-1:XLEN];
    end else begin
      mif.result = prod_fix[XLEN-1:0];
    end
  end

  assign mif.busy = !idle;
  assign mif.done = fin_q;

endmodule

/* hdl/int_alu.sv */
`timescale 1ns/1ps

module int_alu #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  exu_pkg::exu_op_e op_i,
  input  logic             word_i,
  input  logic [XLEN-1:0]  src1_i,
  input  logic [XLEN-1:0]  src2_i,
  output logic [XLEN-1:0]  result_o
);

  import exu_pkg::*;

  // shift amount width, 6 bits for rv64
  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] sh_src;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] raw;
  logic [SHW-1:0]  shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;
  logic            word_ext;

  assign sum  = src1_i + src2_i;
  assign diff = src1_i - src2_i;

  // compare results shared by slt and the branches
  assign lt_s = $signed(src1_i) < $signed(src2_i);
  assign lt_u = src1_i < src2_i;
  assign eq   = src1_i == src2_i;

  // word shifts only look at 5 bits of the amount
  assign shamt = word_i ? SHW'(src2_i[4:0]) : src2_i[SHW-1:0];

  // word shifts run on the low half
  // zero filled for srlw, sign filled for sraw so the right shifts pull in the right bits
  always_comb begin
    if (!word_i) begin
      sh_src = src1_i;
    end else if (op_i == OP_SRA) begin
      sh_src = {{(XLEN-32){src1_i[31]}}, src1_i[31:0]};
    end else begin
      sh_src = {{(XLEN-32){1'b0}}, src1_i[31:0]};
    end
  end

  assign sll_res = sh_src << shamt;
  assign srl_res = sh_src >> shamt;
  assign sra_res = $signed(sh_src) >>> shamt;

  // main result select
  always_comb begin
    raw = '0;
    case (op_i)
      OP_ADD:  raw = sum;
      OP_SUB:  raw = diff;
      OP_SLL:  raw = sll_res;
      OP_SRL:  raw = srl_res;
      OP_SRA:  raw = sra_res;
      OP_AND:  raw = src1_i & src2_i;
      OP_OR:   raw = src1_i | src2_i;
      OP_XOR:  raw = src1_i ^ src2_i;
      OP_SLT:  raw = XLEN'(lt_s);
      OP_SLTU: raw = XLEN'(lt_u);
      // branch taken flags
      OP_BEQ:  raw = XLEN'(eq);
      OP_BNE:  raw = XLEN'(!eq);
      OP_BLT:  raw = XLEN'(lt_s);
      OP_BGE:  raw = XLEN'(!lt_s);
      OP_BLTU: raw = XLEN'(lt_u);
      OP_BGEU: raw = XLEN'(!lt_u);
      // mul and div never take this path
      default: raw = '0;
    endcase
  end

  // word results are sign extended from bit 31
  assign word_ext = word_i && is_word_alu_op(op_i);

  assign result_o = word_ext ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

/* hdl/muldiv_if.sv */
`timescale 1ns/1ps

interface muldiv_if #(
  parameter int XLEN = exu_pkg::XLEN
);

  // request side, held stable by the issuer for the whole operation
  logic            start;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic            word;
  logic            sign_a;
  logic            sign_b;
  // high product or remainder
  logic            alt;

  // response side
  logic            busy;
  logic            done;
  logic [XLEN-1:0] result;

  modport issuer (
    output start, src_a, src_b, word, sign_a, sign_b, alt,
    input  busy, done, result
  );

  modport unit (
    input  start, src_a, src_b, word, sign_a, sign_b, alt,
    output busy, done, result
  );

endinterface

/* hdl/exu_pkg.sv */
package exu_pkg;

  // machine data width
  parameter int XLEN = 64;

  // decoded operation presented to the execute unit
  typedef enum logic [4:0] {
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_SLL    = 5'd2,
    OP_SRL    = 5'd3,
    OP_SRA    = 5'd4,
    OP_AND    = 5'd5,
    OP_OR     = 5'd6,
    OP_XOR    = 5'd7,
    OP_SLT    = 5'd8,
    OP_SLTU   = 5'd9,
    // branch compares, result is 0 or 1
    OP_BEQ    = 5'd10,
    OP_BNE    = 5'd11,
    OP_BLT    = 5'd12,
    OP_BGE    = 5'd13,
    OP_BLTU   = 5'd14,
    OP_BGEU   = 5'd15,
    // rv64m multiply
    OP_MUL    = 5'd16,
    OP_MULH   = 5'd17,
    OP_MULHSU = 5'd18,
    OP_MULHU  = 5'd19,
    // rv64m divide and remainder
    OP_DIV    = 5'd20,
    OP_DIVU   = 5'd21,
    OP_REM    = 5'd22,
    OP_REMU   = 5'd23
  } exu_op_e;

  // handled by the iterative multiplier
  function automatic logic is_mul_op(exu_op_e op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  // handled by the iterative divider
  function automatic logic is_div_op(exu_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  // alu ops that have a word form (addw, subw, sllw, srlw, sraw)
  function automatic logic is_word_alu_op(exu_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA};
  endfunction

endpackage
